// ==== source/spi_config.svh ====
// Bus and register map of the SPI master block
// Offsets are byte addresses inside the block window
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// --------------------
// Bus widths
// --------------------
`define SPI_BUS_ADRS_BIT	16		// Full bus address
`define SPI_BUS_DATA_BIT	32		// Bus data word
`define SPI_BLOCK_ADRS_BIT	8		// Upper block select field
`define SPI_ADRS_MAP		8'h03	// Our block number

// --------------------
// Register offsets
// --------------------
`define SPI_REG_CTRL		8'h00	// bit0 enable / bit1 cs level
`define SPI_REG_DIV			8'h04	// Half period divider
`define SPI_REG_TXD			8'h08	// Write starts a transfer
`define SPI_REG_RXD			8'h0C	// Last received byte
`define SPI_REG_STAT		8'h10	// bit0 busy

// Shift engine widths
`define SPI_DIV_BIT			16
`define SPI_BYTE_BIT		8

`endif

// ==== source/spiPkg.sv ====
// Types shared by the SPI master RTL and its testbench
// Widths come from the config header
`include "spi_config.svh"

package spiPkg;

	// --------------------
	// Bus side
	// --------------------
	typedef logic [`SPI_BUS_ADRS_BIT-1:0]	busAdrsT;	// Block field + offset
	typedef logic [`SPI_BUS_DATA_BIT-1:0]	busDataT;	// Read and write data

	// --------------------
	// SPI side
	// --------------------
	typedef logic [`SPI_BYTE_BIT-1:0]		spiByteT;	// One shifted byte
	typedef logic [`SPI_DIV_BIT-1:0]		spiDivT;	// Half period in sysClk cycles minus one

	// Shift engine states
	typedef enum logic [1:0]
	{
		Idle,		// Waiting for start
		Shift,		// SCLK running
		Finish		// Done strobe cycle
	} spiStateT;

endpackage

// ==== source/spiCsr.sv ====
// Register bank of the SPI master. Bus strobes last one cycle and never stall
// TXD write starts a transfer only with enable set and the unit idle
`timescale 1ns/1ns
`include "spi_config.svh"

module spiCsr (
	input  logic				sysClk,
	input  logic				rst,
	// Bus slave
	input  spiPkg::busDataT		wd,			// Write data
	input  spiPkg::busAdrsT		adrs,		// Access address
	input  logic				wCke,		// Write strobe
	input  logic				rCke,		// Read strobe
	output spiPkg::busDataT		rd,			// Read data
	output logic				rEd,		// Read data valid
	// Unit controls
	output logic				spiEn,
	output logic				csLevel,
	output spiPkg::spiDivT		div,
	output spiPkg::spiByteT		txByte,
	output logic				start,		// One cycle per accepted TXD write
	// Unit status
	input  spiPkg::spiByteT		rxByte,
	input  logic				busy
);

localparam int OfsBit = `SPI_BUS_ADRS_BIT - `SPI_BLOCK_ADRS_BIT;

// --------------------
// Address decode
// --------------------
logic				blockHit;
logic [OfsBit-1:0]	ofs;
logic				wrHit;
logic				rdHit;
logic				txdWrite;

// Upper field selects this block
assign blockHit	= (adrs[`SPI_BUS_ADRS_BIT-1 -: `SPI_BLOCK_ADRS_BIT] == `SPI_ADRS_MAP);
assign ofs		= adrs[OfsBit-1:0];
assign wrHit	= wCke & blockHit;
assign rdHit	= rCke & blockHit;
assign txdWrite	= wrHit & (ofs == `SPI_REG_TXD);

// --------------------
// Write side
// --------------------
always_ff @(posedge sysClk)
begin
	if (rst)
	begin
		spiEn	<= 1'b0;
		csLevel	<= 1'b1;		// cs inactive out of reset
		div		<= '0;
	end
	else if (wrHit)
	begin
		case (ofs)
			`SPI_REG_CTRL:
			begin
				spiEn	<= wd[0];
				csLevel	<= wd[1];
			end
			`SPI_REG_DIV:
			begin
				div		<= wd[`SPI_DIV_BIT-1:0];
			end
			default:
			begin
			end
		endcase
	end
end

// Transmit byte holds its value for readback
always_ff @(posedge sysClk)
begin
	if (txdWrite)
		txByte <= wd[`SPI_BYTE_BIT-1:0];
end

// Start strobe. Blocked while the unit runs or a start is already out
always_ff @(posedge sysClk)
begin
	if (rst)
		start <= 1'b0;
	else
		start <= txdWrite & spiEn & ~busy & ~start;
end

// --------------------
// Read side
// --------------------
spiPkg::busDataT rdMux;

always_comb
begin
	rdMux = '0;		// Unmapped offsets read zero
	case (ofs)
		`SPI_REG_CTRL:
		begin
			rdMux[0] = spiEn;
			rdMux[1] = csLevel;
		end
		`SPI_REG_DIV:	rdMux[`SPI_DIV_BIT-1:0]		= div;
		`SPI_REG_TXD:	rdMux[`SPI_BYTE_BIT-1:0]	= txByte;
		`SPI_REG_RXD:	rdMux[`SPI_BYTE_BIT-1:0]	= rxByte;
		`SPI_REG_STAT:	rdMux[0]					= busy;
		default:
		begin
		end
	endcase
end

// Read data one cycle after rCke
always_ff @(posedge sysClk)
begin
	if (rst)
		rEd <= 1'b0;
	else
		rEd <= rdHit;		// Foreign block gives no rEd
end

always_ff @(posedge sysClk)
begin
	if (rdHit)
		rd <= rdMux;
end

endmodule

// ==== source/spiUnit.sv ====
// SPI mode 0 master engine. One full-duplex byte per start, MSB first
// cs only mirrors csLevel and is never driven by the engine itself
`timescale 1ns/1ns
`include "spi_config.svh"

module spiUnit (
	input  logic				sysClk,
	input  logic				rst,
	// Controls from the register bank
	input  logic				spiEn,
	input  logic				csLevel,
	input  spiPkg::spiDivT		div,		// Half period = div+1 cycles
	input  spiPkg::spiByteT		txByte,
	input  logic				start,
	// Status back
	output spiPkg::spiByteT		rxByte,		// Valid from the done cycle
	output logic				busy,
	output logic				done,		// One cycle at byte end
	// Pins
	output logic				sclk,
	output logic				mosi,
	output logic				cs,
	input  logic				miso
);

// --------------------
// Engine state
// --------------------
spiPkg::spiStateT	state;
spiPkg::spiDivT		halfCnt;		// Cycles into the current half period
logic [2:0]			bitCnt;			// Falling edges so far
spiPkg::spiByteT	txShift;
spiPkg::spiByteT	rxShift;

// Event decode
logic	loadTx;
logic	halfEnd;
logic	shiftTick;
logic	riseEdge;
logic	fallEdge;
logic	lastFall;

assign loadTx		= (state == spiPkg::Idle) & start & spiEn;
assign halfEnd		= (halfCnt == div);
assign shiftTick	= (state == spiPkg::Shift) & spiEn & halfEnd;	// sclk flips here
assign riseEdge		= shiftTick & ~sclk;
assign fallEdge		= shiftTick & sclk;
assign lastFall		= fallEdge & (bitCnt == 3'd7);				// Eighth pulse ends

// --------------------
// FSM and SCLK
// --------------------
always_ff @(posedge sysClk)
begin
	if (rst)
	begin
		state	<= spiPkg::Idle;
		sclk	<= 1'b0;
		halfCnt	<= '0;
		bitCnt	<= '0;
	end
	else
	begin
		case (state)
			spiPkg::Idle:
			begin
				sclk	<= 1'b0;		// Mode 0 idles low
				halfCnt	<= '0;
				bitCnt	<= '0;
				if (loadTx)
					state <= spiPkg::Shift;
			end

			spiPkg::Shift:
			begin
				if (!spiEn)
				begin
					// Abort, no done strobe
					state	<= spiPkg::Idle;
					sclk	<= 1'b0;
				end
				else if (halfEnd)
				begin
					halfCnt	<= '0;
					sclk	<= ~sclk;
					if (fallEdge)
						bitCnt <= bitCnt + 3'd1;	// Wraps to zero after bit 7
					if (lastFall)
						state <= spiPkg::Finish;
				end
				else
				begin
					halfCnt <= halfCnt + 1'b1;
				end
			end

			spiPkg::Finish:
			begin
				state <= spiPkg::Idle;	// Single done cycle
			end

			default:
			begin
				state <= spiPkg::Idle;
			end
		endcase
	end
end

// --------------------
// Shift registers
// --------------------
// Transmit side loads on start and moves on falling edges
always_ff @(posedge sysClk)
begin
	if (loadTx)
		txShift <= txByte;
	else if (fallEdge)
		txShift <= {txShift[`SPI_BYTE_BIT-2:0], 1'b0};
end

// Receive side samples miso on rising edges
always_ff @(posedge sysClk)
begin
	if (riseEdge)
		rxShift <= {rxShift[`SPI_BYTE_BIT-2:0], miso};
end

// Completed byte kept apart from the shifter. An aborted byte never lands here
always_ff @(posedge sysClk)
begin
	if (lastFall)
		rxByte <= rxShift;
end

// --------------------
// Outputs
// --------------------
assign mosi	= txShift[`SPI_BYTE_BIT-1];			// MSB first
assign busy	= (state != spiPkg::Idle);			// Shift and Finish
assign done	= (state == spiPkg::Finish);
assign cs	= csLevel;							// Software owns chip select

endmodule

// ==== source/spiBlock.sv ====
// SPI master block on the internal register bus. Master mode only
// Block address and register map come from the config header
`timescale 1ns/1ns

module spiBlock (
	input  logic				sysClk,
	input  logic				rst,
	// Bus slave
	input  spiPkg::busDataT		wd,			// Write data
	input  spiPkg::busAdrsT		adrs,		// Access address
	input  logic				wCke,		// Write strobe
	input  logic				rCke,		// Read strobe
	output spiPkg::busDataT		rd,			// Read data
	output logic				rEd,		// Read data valid
	// SPI pins
	output logic				sclk,
	output logic				mosi,
	input  logic				miso,
	output logic				cs,
	// Interrupt
	output logic				intr		// Byte done
);

// --------------------
// Register bank to engine
// --------------------
logic				spiEn;
logic				csLevel;
spiPkg::spiDivT		div;
spiPkg::spiByteT	txByte;
logic				start;

// Engine back to register bank
spiPkg::spiByteT	rxByte;
logic				busy;

spiCsr spiCsrInst (
	.sysClk		(sysClk),
	.rst		(rst),
	// Bus
	.wd			(wd),
	.adrs		(adrs),
	.wCke		(wCke),
	.rCke		(rCke),
	.rd			(rd),
	.rEd		(rEd),
	// Controls
	.spiEn		(spiEn),
	.csLevel	(csLevel),
	.div		(div),
	.txByte		(txByte),
	.start		(start),
	// Status
	.rxByte		(rxByte),
	.busy		(busy)
);

// --------------------
// Shift engine
// --------------------
spiUnit spiUnitInst (
	.sysClk		(sysClk),
	.rst		(rst),
	.spiEn		(spiEn),
	.csLevel	(csLevel),
	.div		(div),
	.txByte		(txByte),
	.start		(start),
	.rxByte		(rxByte),
	.busy		(busy),
	.done		(intr),		// Done strobe is the interrupt
	.sclk		(sclk),
	.mosi		(mosi),
	.cs			(cs),
	.miso		(miso)
);

endmodule

// ==== verification/spiSlaveModel.sv ====
// Behavioral SPI mode 0 slave. Shifts only while cs is low
// A rising edge on load preloads the reply byte and clears the pulse count
`timescale 1ns/1ns
`include "spi_config.svh"

module spiSlaveModel (
	input  logic				sclk,
	input  logic				mosi,
	input  logic				cs,
	output logic				miso,
	input  spiPkg::spiByteT		loadByte,	// Reply for the next transfer
	input  logic				load,
	output spiPkg::spiByteT		rxd,		// Last eight bits seen on mosi
	output int					pulses		// Completed SCLK pulses since load
);

spiPkg::spiByteT txReg = '0;

assign miso = txReg[`SPI_BYTE_BIT-1];		// MSB first and valid before the first rise

// Reply side moves on the falling edge
always @(posedge load or negedge sclk)
begin
	if (load)
	begin
		txReg	<= loadByte;
		pulses	<= 0;
	end
	else
	begin
		pulses <= pulses + 1;
		if (!cs)
			txReg <= {txReg[`SPI_BYTE_BIT-2:0], 1'b0};
	end
end

// Sample mosi on the rising edge
always @(posedge sclk)
begin
	if (!cs)
		rxd <= {rxd[`SPI_BYTE_BIT-2:0], mosi};
end

endmodule

// ==== verification/spiBlock_props.sv ====
// Concurrent checks on the SPI pins, interrupt and bus read timing
// Bound into every spiBlock instance
`timescale 1ns/1ns
`include "spi_config.svh"

module spiBlockProps (
	input  logic				sysClk,
	input  logic				rst,
	input  logic				sclk,
	input  logic				intr,
	input  logic				busy,
	input  logic				rCke,
	input  logic				rEd,
	input  spiPkg::busAdrsT		adrs
);

logic readHit;		// Read strobe aimed at this block

assign readHit = rCke & (adrs[`SPI_BUS_ADRS_BIT-1 -: `SPI_BLOCK_ADRS_BIT] == `SPI_ADRS_MAP);

// --------------------
// Pin and strobe rules
// --------------------
sclkIdleLow: assert property (@(posedge sysClk) disable iff (rst) !busy |-> !sclk)
	else $error("sclk high while the engine is idle");

intrOneCycle: assert property (@(posedge sysClk) disable iff (rst) intr |=> !intr)
	else $error("intr held longer than one cycle");

rEdAfterHit: assert property (@(posedge sysClk) disable iff (rst) readHit |=> rEd)
	else $error("rEd missing one cycle after a block read");

rEdOnlyOnHit: assert property (@(posedge sysClk) disable iff (rst) rEd |-> $past(readHit))
	else $error("rEd without a block read in the cycle before");

endmodule

bind spiBlock spiBlockProps propsInst (
	.sysClk	(sysClk),
	.rst	(rst),
	.sclk	(sclk),
	.intr	(intr),
	.busy	(busy),
	.rCke	(rCke),
	.rEd	(rEd),
	.adrs	(adrs)
);

// ==== verification/spiBlockTb.sv ====
// Directed testbench for the SPI master block, stops at the first error
// Inputs change on the rising clock edge, outputs are sampled on the falling edge
`timescale 1ns/1ns
`include "spi_config.svh"

module spiBlockTb;

localparam int			NumTests		= 5;
localparam int			MaxDiv			= 3;						// Largest divider used
localparam int			XferCycles		= 16 * (MaxDiv + 1) + 1;	// Worst case transfer
localparam int			TimeoutCycles	= NumTests * 8 * (XferCycles + 16);
localparam logic [7:0]	OtherBlock		= 8'h5c;					// Foreign block field

logic				sysClk;
logic				rst;
spiPkg::busDataT	wd;
spiPkg::busAdrsT	adrs;
logic				wCke;
logic				rCke;
spiPkg::busDataT	rd;
logic				rEd;
logic				sclk;
logic				mosi;
logic				miso;
logic				cs;
logic				intr;
spiPkg::spiByteT	slaveByte;		// Slave model preload
logic				slaveLoad;
spiPkg::spiByteT	slaveRxd;
int					slavePulses;
logic [31:0]		lfsr		= 32'hdb78;
int					cycleCount	= 0;

spiBlock uut (.sysClk(sysClk), .rst(rst), .wd(wd), .adrs(adrs), .wCke(wCke), .rCke(rCke),
	.rd(rd), .rEd(rEd), .sclk(sclk), .mosi(mosi), .miso(miso), .cs(cs), .intr(intr));

spiSlaveModel slave (.sclk(sclk), .mosi(mosi), .cs(cs), .miso(miso), .loadByte(slaveByte),
	.load(slaveLoad), .rxd(slaveRxd), .pulses(slavePulses));

initial
begin
	sysClk = 1'b0;
	forever #20 sysClk = ~sysClk;		// 40 ns period
end

// --------------------
// Helpers
// --------------------
task automatic failRun(input string why);
	$display("%s", why);
	$display("Simulation FAILED");
	$fatal(1, "stopped at the first error");
endtask

task automatic check(input string name, input spiPkg::busDataT exp, input spiPkg::busDataT act);
	if (exp !== act)
		failRun($sformatf("CHECK FAILED %s expected %0h actual %0h", name, exp, act));
endtask

always @(posedge sysClk)
begin
	cycleCount <= cycleCount + 1;
	if (cycleCount > TimeoutCycles)
		failRun("Timeout, the run went past its cycle limit");
end

// Taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic randByte(output spiPkg::spiByteT b);
	for (int i = 0; i < 8; i++)
	begin
		lfsr	= lfsrNext(lfsr);			// One step per bit
		b		= {b[6:0], lfsr[0]};
	end
endtask

function automatic spiPkg::busAdrsT adrsOf(input logic [7:0] blk, input logic [7:0] ofs);
	return {blk, ofs};
endfunction

task automatic busWrite(input spiPkg::busAdrsT a, input spiPkg::busDataT d);
	@(posedge sysClk);
	adrs	<= a;
	wd		<= d;
	wCke	<= 1'b1;
	@(posedge sysClk);
	wCke	<= 1'b0;
endtask

// rEd must be low in the rCke cycle and high in the next
task automatic busRead(input spiPkg::busAdrsT a, output spiPkg::busDataT d);
	@(posedge sysClk);
	adrs	<= a;
	rCke	<= 1'b1;
	@(negedge sysClk);
	if (rEd)
		failRun("rEd came in the same cycle as rCke");
	@(posedge sysClk);
	rCke	<= 1'b0;
	@(negedge sysClk);
	if (!rEd)
		failRun("rEd missing one cycle after rCke");
	d = rd;
endtask

task automatic loadSlave(input spiPkg::spiByteT b);
	@(posedge sysClk);
	slaveByte <= b;					// Settles before the load edge
	@(posedge sysClk);
	slaveLoad <= 1'b1;
	@(posedge sysClk);
	slaveLoad <= 1'b0;
endtask

task automatic waitIntr(input int div);
	int n;
	n = 0;
	@(negedge sysClk);
	while (!intr)
	begin
		n++;
		if (n > 16 * (div + 1) + 8)
			failRun("intr did not arrive within one transfer time");
		@(negedge sysClk);
	end
endtask

task automatic quietWatch(input string name, input int cycles);
	repeat (cycles)
	begin
		@(negedge sysClk);
		if (sclk || intr)
			failRun($sformatf("%s caused SCLK or intr activity", name));
	end
endtask

// Pin level high and low times until intr
task automatic measureSclk(input int div);
	int		highLen;
	int		lowLen;
	int		pulseCnt;
	int		n;
	logic	prev;
	logic	fin;
	highLen		= 0;
	lowLen		= 0;
	pulseCnt	= 0;
	n			= 0;
	prev		= 1'b0;
	fin			= 1'b0;
	while (!fin)
	begin
		@(negedge sysClk);
		n++;
		if (n > 16 * (div + 1) + 8)
			failRun("intr did not arrive while measuring SCLK");
		if (sclk && !prev)
		begin
			if (pulseCnt > 0)
				check("sclk low time", div + 1, lowLen);	// Gap between pulses
			pulseCnt++;
			highLen = 0;
		end
		if (!sclk && prev)
		begin
			check("sclk high time", div + 1, highLen);
			lowLen = 0;
		end
		if (sclk)
			highLen++;
		else
			lowLen++;
		prev	= sclk;
		fin		= intr;
	end
	check("sclk pulse count", 8, pulseCnt);
endtask

// --------------------
// Tests
// --------------------
task automatic testRegReadback();
	spiPkg::busDataT d;
	busRead(adrsOf(`SPI_ADRS_MAP, `SPI_REG_CTRL), d);
	check("ctrl after reset", 32'h2, d);		// cs level high, enable off
	check("cs pin after reset", 32'h1, 32'(cs));
	busRead(adrsOf(`SPI_ADRS_MAP, `SPI_REG_DIV), d);
	check("div after reset", 32'h0, d);
	busRead(adrsOf(`SPI_ADRS_MAP, `SPI_REG_STAT), d);
	check("stat after reset", 32'h0, d);
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_CTRL), 32'hffff_fffe);
	busRead(adrsOf(`SPI_ADRS_MAP, `SPI_REG_CTRL), d);
	check("ctrl readback", 32'h2, d);
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_DIV), 32'h1234_abcd);
	busRead(adrsOf(`SPI_ADRS_MAP, `SPI_REG_DIV), d);
	check("div readback", 32'h0000_abcd, d);
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_TXD), 32'h5a5a_c3a5);
	busRead(adrsOf(`SPI_ADRS_MAP, `SPI_REG_TXD), d);
	check("txd readback", 32'h0000_00a5, d);
	busRead(adrsOf(`SPI_ADRS_MAP, 8'h14), d);
	check("unmapped 0x14", 32'h0, d);
	busRead(adrsOf(`SPI_ADRS_MAP, 8'hfc), d);
	check("unmapped 0xfc", 32'h0, d);
endtask

task automatic testByteExchange();
	spiPkg::busDataT	d;
	spiPkg::spiByteT	txb;
	spiPkg::spiByteT	rxb;
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_DIV), 32'h1);
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_CTRL), 32'h1);		// Enable, cs low
	for (int i = 0; i < 4; i++)
	begin
		randByte(txb);
		randByte(rxb);
		loadSlave(rxb);
		busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_TXD), 32'(txb));
		waitIntr(1);
		check("exchange byte at slave", 32'(txb), 32'(slaveRxd));
		busRead(adrsOf(`SPI_ADRS_MAP, `SPI_REG_RXD), d);
		check("exchange rxd readback", 32'(rxb), d);
	end
endtask

task automatic testDividerTiming();
	spiPkg::spiByteT	b;
	int					dv;
	for (int k = 0; k < 3; k++)
	begin
		dv = (k == 2) ? MaxDiv : k;		// 0 1 3
		busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_DIV), 32'(dv));
		randByte(b);
		loadSlave(b);
		busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_TXD), 32'(b));
		measureSclk(dv);
		check("divider byte at slave", 32'(b), 32'(slaveRxd));
	end
endtask

task automatic testCsBusy();
	spiPkg::busDataT	d;
	spiPkg::spiByteT	txb;
	spiPkg::spiByteT	rxb;
	spiPkg::spiByteT	late;
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_CTRL), 32'h2);
	@(negedge sysClk);
	check("cs follows ctrl high", 32'h1, 32'(cs));
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_CTRL), 32'h0);
	@(negedge sysClk);
	check("cs follows ctrl low", 32'h0, 32'(cs));
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_CTRL), 32'h1);
	randByte(txb);
	randByte(rxb);
	late = ~txb;					// Differs in every bit
	loadSlave(rxb);
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_TXD), 32'(txb));
	busRead(adrsOf(`SPI_ADRS_MAP, `SPI_REG_STAT), d);
	check("busy during transfer", 32'h1, d);
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_TXD), 32'(late));	// Must be dropped
	waitIntr(MaxDiv);
	check("byte kept over busy write", 32'(txb), 32'(slaveRxd));
	busRead(adrsOf(`SPI_ADRS_MAP, `SPI_REG_STAT), d);
	check("busy after transfer", 32'h0, d);
	quietWatch("dropped TXD write", 20);
	check("pulses of one transfer", 32'd8, slavePulses);
endtask

task automatic testFilterGate();
	loadSlave(8'h3c);
	busWrite(adrsOf(OtherBlock, `SPI_REG_TXD), 32'h96);
	quietWatch("Foreign block TXD write", 40);
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_CTRL), 32'h0);		// Enable off
	busWrite(adrsOf(`SPI_ADRS_MAP, `SPI_REG_TXD), 32'h69);
	quietWatch("TXD write with enable clear", 40);
	check("no pulses while gated", 32'd0, slavePulses);
	@(posedge sysClk);
	adrs <= adrsOf(OtherBlock, `SPI_REG_CTRL);
	rCke <= 1'b1;
	@(posedge sysClk);
	rCke <= 1'b0;
	repeat (2)
	begin
		@(negedge sysClk);
		if (rEd)
			failRun("rEd answered a read of a foreign block");
	end
endtask

// --------------------
// Main sequence
// --------------------
initial
begin
	rst			= 1'b1;
	wd			= '0;
	adrs		= '0;
	wCke		= 1'b0;
	rCke		= 1'b0;
	slaveByte	= '0;
	slaveLoad	= 1'b0;
	repeat (8) @(posedge sysClk);
	rst <= 1'b0;
	testRegReadback();
	testByteExchange();
	testDividerTiming();
	testCsBusy();
	testFilterGate();
	$display("Simulation PASSED");
	$finish;
end

endmodule

// ==== spiBlock.f ====
+incdir+source
source/spiPkg.sv
source/spiCsr.sv
source/spiUnit.sv
source/spiBlock.sv
verification/spiSlaveModel.sv
verification/spiBlock_props.sv
verification/spiBlockTb.sv

// ==== Makefile ====
# Verilator build and run of the SPI master block testbench
VERILATOR := verilator
TOP       := spiBlockTb
RTLTOP    := spiBlock
FILELIST  := spiBlock.f
OBJDIR    := obj_dir
FLAGS     := --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ns -Wall

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(FILELIST) $(wildcard source/*.sv source/*.svh verification/*.sv)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
